/* tb/coreVectors.mem */
// Words 000-07F are RV32I machine code, word index = pc / 4, six words per line
// Word 080 is the expected store count N, then N (address, data) pairs in store order
@000
12300093 FF000113 800001B7 00400393 00208233 402082B3 // 000 setup, add, sub
00709333 00112433 001134B3 0020C533 0071D5B3 4071D633 // 018 sll slt sltu xor srl sra
0020E6B3 0020F733 00402023 00502223 00602423 00802623 // 030 or and, R-type stores
00902823 00A02A23 00B02C23 00C02E23 02D02023 02E02223 // 048
02302423 FDD08793 FF112813 1240B893 0FF0C913 4000E993 // 060 lui store, I-type ops
0F717A13 00809A93 01F1DB13 41F1DB93 12345C17 02F02623 // 078 andi shifts auipc
03002823 03102A23 03202C23 03302E23 05402023 05502223 // 090 I-type stores
05602423 05702623 05802823 00700C93 001C8D13 002C8D93 // 0A8 forwarding chain
003C8E13 01BD0EB3 05D02A23 05C02C23 001C8C93 001C8C93 // 0C0
05902E23 04402F03 005F0F93 07F02023 00802F03 07E02223 // 0D8 load-use pairs
00108663 0E302E23 0E302E23 00208663 06102423 00209663 // 0F0 beq taken, not taken
0E302E23 0E302E23 00109663 06202623 00114663 0E302E23 // 108 bne, blt
0E302E23 0020C663 06102823 0020D663 0E302E23 0E302E23 // 120 blt, bge
00115663 06202A23 0020E663 0E302E23 0E302E23 00116663 // 138 bge, bltu
06102C23 00117663 0E302E23 0E302E23 0020F663 06202E23 // 150 bgeu
00C002EF 0E302E23 0E302E23 08502023 18800313 001303E7 // 168 jal, jalr
0E302E23 0E302E23 08702223 0000006F 0E302E23 0E302E23 // 180 link store, self-jump
@080
00000022
@081
00000000 00000113 00000004 00000133 00000008 00001230
0000000C 00000001 00000010 00000000 00000014 FFFFFED3
00000018 08000000 0000001C F8000000 00000020 FFFFFFF3
00000024 00000120 00000028 80000000 0000002C 00000100
00000030 00000001 00000034 00000001 00000038 000001DC
0000003C 00000523 00000040 000000F0 00000044 00012300
00000048 00000001 0000004C FFFFFFFF 00000050 12345088
00000054 00000011 00000058 0000000A 0000005C 00000009
00000060 00012305 00000064 00001230 00000068 00000123
0000006C FFFFFFF0 00000070 00000123 00000074 FFFFFFF0
00000078 00000123 0000007C FFFFFFF0 00000080 0000016C
00000084 00000180

/* compile.f */
rtl/rvIsaPkg.sv
rtl/corePipePkg.sv
rtl/regFile.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memWbStage.sv
rtl/bigCore.sv
tb/tbBigCore.sv

/* Makefile */
# Verilator build and run for the RV32I core testbench

VERILATOR ?= verilator
TOP       ?= tbBigCore
FLIST     ?= compile.f
VECTORS   ?= tb/coreVectors.mem
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Regression passed

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN) $(VECTORS)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/tbBigCore.sv */
// Testbench for the RV32I core that runs the vectors-file program and checks every store
`timescale 1ns/1ps
`default_nettype none

module tbBigCore;
  import corePipePkg::*;

  localparam int    VecWords    = 256;    // Program plus expected stores
  localparam int    CountIdx    = 128;    // Expected store count lives here
  localparam int    DMemWords   = 64;
  localparam int    ResetCycles = 4;
  localparam int    StoreLimit  = 2000;   // Cycles allowed for all stores
  localparam int    DrainCycles = 40;     // Core spins on its self-jump here
  localparam string VecFile     = "tb/coreVectors.mem";

  logic Clk;
  logic rst;
  tWord pcQ100H;
  tWord instrQ101H;
  tWord dMemAddrQ103H;
  tWord dMemWrDataQ103H;
  logic dMemWrEnQ103H;
  logic dMemRdEnQ103H;
  tWord dMemRdDataQ104H;

  tWord vecMem [0:VecWords-1];
  tWord dMem   [0:DMemWords-1];
  int   expCount;
  int   storeCount;
  int   waitCycles;

  bigCore dut (
    .Clk             (Clk),
    .rst             (rst),
    .pcQ100H         (pcQ100H),
    .instrQ101H      (instrQ101H),
    .dMemAddrQ103H   (dMemAddrQ103H),
    .dMemWrDataQ103H (dMemWrDataQ103H),
    .dMemWrEnQ103H   (dMemWrEnQ103H),
    .dMemRdEnQ103H   (dMemRdEnQ103H),
    .dMemRdDataQ104H (dMemRdDataQ104H)
  );

  always #4 Clk = ~Clk;   // 8 ns period

  // Single compare point for every value check
  task automatic compareWord(input string name, input tWord expected, input tWord actual);
    if (actual !== expected) begin
      $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
               $time, name, expected, actual);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Memory models
  ////////////////////////////////////////////////////////////
  always @(posedge Clk) begin
    instrQ101H <= vecMem[{1'b0, pcQ100H[8:2]}];   // Word pc/4 one cycle later
  end

  always @(posedge Clk) begin
    if (dMemWrEnQ103H === 1'b1) begin
      dMem[dMemAddrQ103H[7:2]] <= dMemWrDataQ103H;
    end
    if (dMemRdEnQ103H === 1'b1) begin
      dMemRdDataQ104H <= dMem[dMemAddrQ103H[7:2]];   // Q104H read data
    end
  end

  ////////////////////////////////////////////////////////////
  // Store checker
  ////////////////////////////////////////////////////////////
  // Sampled mid-cycle where the Q103H strobes are settled
  always @(negedge Clk) begin
    if (!rst && (dMemWrEnQ103H === 1'b1)) begin
      if (storeCount >= expCount) begin
        $display("ERROR: unexpected store to address %h at %0t after all %0d expected stores",
                 dMemAddrQ103H, $time, expCount);
        $display("Regression failed");
        $fatal(1);
      end else begin
        compareWord("dMemAddrQ103H", vecMem[CountIdx + 1 + 2 * storeCount], dMemAddrQ103H);
        compareWord("dMemWrDataQ103H", vecMem[CountIdx + 2 + 2 * storeCount],
                    dMemWrDataQ103H);
        storeCount = storeCount + 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    Clk             = 1'b0;
    rst             = 1'b1;
    instrQ101H      = '0;
    dMemRdDataQ104H = '0;
    storeCount      = 0;
    waitCycles      = 0;
    $readmemh(VecFile, vecMem);
    expCount = int'(vecMem[CountIdx]);
    for (int i = 0; i < DMemWords; i++) begin
      dMem[i] = 32'hDA7A_0000 ^ tWord'(i << 2);   // Byte address in the low bits
    end

    // Reset held for 4 edges and strobes quiet through the first free cycle
    for (int cyc = 0; cyc < ResetCycles; cyc++) begin
      @(posedge Clk);
      if (cyc == ResetCycles - 1) begin
        rst <= 1'b0;
      end
      @(negedge Clk);
      compareWord("pcQ100H", 32'h0000_0000, pcQ100H);
      compareWord("dMemWrEnQ103H", '0, tWord'(dMemWrEnQ103H));
      compareWord("dMemRdEnQ103H", '0, tWord'(dMemRdEnQ103H));
    end

    while ((storeCount < expCount) && (waitCycles < StoreLimit)) begin
      @(posedge Clk);
      waitCycles++;
    end

    if (storeCount < expCount) begin
      $display("ERROR: only %0d of %0d stores arrived within %0d cycles",
               storeCount, expCount, StoreLimit);
      $display("Regression failed");
      $fatal(1);
    end else begin
      repeat (DrainCycles) @(posedge Clk);       // Any extra store trips the checker
      $display("Regression passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* rtl/bigCore.sv */
// Top of the five-stage RV32I core chaining fetch and decode and execute and memory stages
`timescale 1ns/1ps
`default_nettype none

module bigCore (
  input  logic              Clk,
  input  logic              rst,
  // Instruction memory
  output corePipePkg::tWord pcQ100H,
  input  corePipePkg::tWord instrQ101H,
  // Data memory
  output corePipePkg::tWord dMemAddrQ103H,
  output corePipePkg::tWord dMemWrDataQ103H,
  output logic              dMemWrEnQ103H,
  output logic              dMemRdEnQ103H,
  input  corePipePkg::tWord dMemRdDataQ104H
);
  import corePipePkg::*;

  tWord   pcQ101H;
  tWord   pcPlus4Q101H;
  logic   stallQ101H;        // Load-use bubble
  logic   redirectQ102H;     // Taken branch or jump
  tWord   redirectPcQ102H;
  tDecExe decExeQ102H;
  tExeMem exeMemQ103H;
  tWrBack exeMemFwd;
  tWrBack wrBackQ104H;

  fetchStage uFetch (
    .Clk             (Clk),
    .rst             (rst),
    .stallQ101H      (stallQ101H),
    .redirectQ102H   (redirectQ102H),
    .redirectPcQ102H (redirectPcQ102H),
    .pcQ100H         (pcQ100H),
    .pcQ101H         (pcQ101H),
    .pcPlus4Q101H    (pcPlus4Q101H)
  );

  decodeStage uDecode (
    .Clk           (Clk),
    .rst           (rst),
    .instrQ101H    (instrQ101H),
    .pcQ101H       (pcQ101H),
    .pcPlus4Q101H  (pcPlus4Q101H),
    .redirectQ102H (redirectQ102H),
    .wrBackQ104H   (wrBackQ104H),
    .decExeQ102H   (decExeQ102H),
    .stallQ101H    (stallQ101H)
  );

  executeStage uExecute (
    .Clk             (Clk),
    .rst             (rst),
    .decExeQ102H     (decExeQ102H),
    .exeMemFwd       (exeMemFwd),
    .wrBackQ104H     (wrBackQ104H),
    .redirectQ102H   (redirectQ102H),
    .redirectPcQ102H (redirectPcQ102H),
    .exeMemQ103H     (exeMemQ103H)
  );

  memWbStage uMemWb (
    .Clk             (Clk),
    .rst             (rst),
    .exeMemQ103H     (exeMemQ103H),
    .dMemRdDataQ104H (dMemRdDataQ104H),
    .dMemAddrQ103H   (dMemAddrQ103H),
    .dMemWrDataQ103H (dMemWrDataQ103H),
    .dMemWrEnQ103H   (dMemWrEnQ103H),
    .dMemRdEnQ103H   (dMemRdEnQ103H),
    .exeMemFwd       (exeMemFwd),
    .wrBackQ104H     (wrBackQ104H)
  );

endmodule

`default_nettype wire

/* rtl/memWbStage.sv */
// Memory access and write-back stages driving the data memory and the register write port
`timescale 1ns/1ps
`default_nettype none

module memWbStage (
  input  logic                Clk,
  input  logic                rst,
  input  corePipePkg::tExeMem exeMemQ103H,
  input  corePipePkg::tWord   dMemRdDataQ104H,   // From data memory
  output corePipePkg::tWord   dMemAddrQ103H,
  output corePipePkg::tWord   dMemWrDataQ103H,
  output logic                dMemWrEnQ103H,
  output logic                dMemRdEnQ103H,
  output corePipePkg::tWrBack exeMemFwd,
  output corePipePkg::tWrBack wrBackQ104H
);
  import corePipePkg::*;

  tMemWb memWbQ103H;
  tMemWb memWbQ104H;

  // Data memory port
  assign dMemAddrQ103H   = exeMemQ103H.aluOut;
  assign dMemWrDataQ103H = exeMemQ103H.storeData;
  assign dMemWrEnQ103H   = exeMemQ103H.valid && exeMemQ103H.isStore;
  assign dMemRdEnQ103H   = exeMemQ103H.valid && exeMemQ103H.isLoad;

  // Load data not here yet so loads do not forward from Q103H
  assign exeMemFwd.wrEn = exeMemQ103H.valid && exeMemQ103H.regWrEn && !exeMemQ103H.isLoad;
  assign exeMemFwd.rd   = exeMemQ103H.rd;
  assign exeMemFwd.data = exeMemQ103H.selWrPc ? exeMemQ103H.pcPlus4 : exeMemQ103H.aluOut;

  assign memWbQ103H = '{
    valid:   exeMemQ103H.valid,
    aluOut:  exeMemQ103H.aluOut,
    rd:      exeMemQ103H.rd,
    regWrEn: exeMemQ103H.regWrEn,
    isLoad:  exeMemQ103H.isLoad,
    selWrPc: exeMemQ103H.selWrPc,
    pcPlus4: exeMemQ103H.pcPlus4
  };

  // Q103H to Q104H register
  always_ff @(posedge Clk) begin
    memWbQ104H <= memWbQ103H;
    if (rst) begin
      memWbQ104H.valid <= 1'b0;
    end
  end

  // Write-back select
  always_comb begin
    wrBackQ104H.wrEn = memWbQ104H.valid && memWbQ104H.regWrEn;
    wrBackQ104H.rd   = memWbQ104H.rd;
    if (memWbQ104H.isLoad) begin
      wrBackQ104H.data = dMemRdDataQ104H;              // Full word as is
    end else if (memWbQ104H.selWrPc) begin
      wrBackQ104H.data = memWbQ104H.pcPlus4;           // JAL and JALR link
    end else begin
      wrBackQ104H.data = memWbQ104H.aluOut;
    end
  end

  // Decode never marks one instruction as both load and store
  assert property (@(posedge Clk) disable iff (rst) !(dMemWrEnQ103H && dMemRdEnQ103H))
    else $error("data memory read and write strobes together");

endmodule

`default_nettype wire

/* rtl/executeStage.sv */
// Execute stage with operand forwarding and ALU and branch resolution into Q103H
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  input  logic                Clk,
  input  logic                rst,
  input  corePipePkg::tDecExe decExeQ102H,
  input  corePipePkg::tWrBack exeMemFwd,        // Q103H result
  input  corePipePkg::tWrBack wrBackQ104H,
  output logic                redirectQ102H,
  output corePipePkg::tWord   redirectPcQ102H,
  output corePipePkg::tExeMem exeMemQ103H
);
  import corePipePkg::*;
  import rvIsaPkg::*;

  tWord              rs1FwdQ102H;
  tWord              rs2FwdQ102H;
  tWord              aluIn1Q102H;
  tWord              aluIn2Q102H;
  logic [ShamtW-1:0] shamtQ102H;
  tWord              aluOutQ102H;
  logic              branchTakenQ102H;
  tExeMem            exeMemQ102H;

  // Youngest producer wins
  function automatic tWord fwdSel(tRegAddr rs, tWord rfData, tWrBack q103, tWrBack q104);
    if ((rs != '0) && q103.wrEn && (q103.rd == rs)) return q103.data;
    if ((rs != '0) && q104.wrEn && (q104.rd == rs)) return q104.data;
    return rfData;
  endfunction

  assign rs1FwdQ102H = fwdSel(decExeQ102H.rs1, decExeQ102H.rs1Data, exeMemFwd, wrBackQ104H);
  assign rs2FwdQ102H = fwdSel(decExeQ102H.rs2, decExeQ102H.rs2Data, exeMemFwd, wrBackQ104H);

  ////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////
  assign aluIn1Q102H = decExeQ102H.selAluPc ? decExeQ102H.pc : rs1FwdQ102H;
  assign aluIn2Q102H = decExeQ102H.selAluImm ? decExeQ102H.imm : rs2FwdQ102H;
  assign shamtQ102H  = aluIn2Q102H[ShamtW-1:0];

  always_comb begin
    case (decExeQ102H.aluOp)
      Sub:     aluOutQ102H = aluIn1Q102H - aluIn2Q102H;
      Sll:     aluOutQ102H = aluIn1Q102H << shamtQ102H;
      Slt:     aluOutQ102H = tWord'($signed(aluIn1Q102H) < $signed(aluIn2Q102H));
      Sltu:    aluOutQ102H = tWord'(aluIn1Q102H < aluIn2Q102H);
      Xor:     aluOutQ102H = aluIn1Q102H ^ aluIn2Q102H;
      Srl:     aluOutQ102H = aluIn1Q102H >> shamtQ102H;
      Sra:     aluOutQ102H = tWord'($signed(aluIn1Q102H) >>> shamtQ102H);
      Or:      aluOutQ102H = aluIn1Q102H | aluIn2Q102H;
      And:     aluOutQ102H = aluIn1Q102H & aluIn2Q102H;
      default: aluOutQ102H = aluIn1Q102H + aluIn2Q102H;   // Also loads and stores and targets
    endcase
    if (decExeQ102H.isLui) begin
      aluOutQ102H = aluIn2Q102H;                          // Upper immediate as is
    end
  end

  ////////////////////////////////////////////////////////////
  // Branch compare and redirect
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (decExeQ102H.branchOp)
      Beq:     branchTakenQ102H = (rs1FwdQ102H == rs2FwdQ102H);
      Bne:     branchTakenQ102H = (rs1FwdQ102H != rs2FwdQ102H);
      Blt:     branchTakenQ102H = ($signed(rs1FwdQ102H) < $signed(rs2FwdQ102H));
      Bge:     branchTakenQ102H = ($signed(rs1FwdQ102H) >= $signed(rs2FwdQ102H));
      Bltu:    branchTakenQ102H = (rs1FwdQ102H < rs2FwdQ102H);
      Bgeu:    branchTakenQ102H = (rs1FwdQ102H >= rs2FwdQ102H);
      default: branchTakenQ102H = 1'b0;
    endcase
  end

  assign redirectQ102H = decExeQ102H.valid &&
                         ((decExeQ102H.isBranch && branchTakenQ102H) || decExeQ102H.isJump);
  assign redirectPcQ102H = {aluOutQ102H[Xlen-1:1], 1'b0};   // JALR drops bit 0

  always_comb begin
    exeMemQ102H.valid     = decExeQ102H.valid;
    exeMemQ102H.aluOut    = aluOutQ102H;
    exeMemQ102H.storeData = rs2FwdQ102H;        // SW data after forwarding
    exeMemQ102H.rd        = decExeQ102H.rd;
    exeMemQ102H.regWrEn   = decExeQ102H.regWrEn;
    exeMemQ102H.isLoad    = decExeQ102H.isLoad;
    exeMemQ102H.isStore   = decExeQ102H.isStore;
    exeMemQ102H.selWrPc   = decExeQ102H.isJump;
    exeMemQ102H.pcPlus4   = decExeQ102H.pcPlus4;
  end

  // Q102H to Q103H register
  always_ff @(posedge Clk) begin
    exeMemQ103H <= exeMemQ102H;
    if (rst) begin
      exeMemQ103H.valid <= 1'b0;
    end
  end

  // Decode must bubble both younger slots
  assert property (@(posedge Clk) disable iff (rst)
    redirectQ102H |-> decExeQ102H.valid ##1 !decExeQ102H.valid ##1 !decExeQ102H.valid)
    else $error("redirect without a two-slot flush");

endmodule

`default_nettype wire

/* rtl/decodeStage.sv */
// Decode stage with control decode and immediate build and the load-use stall into Q102H
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
  input  logic                Clk,
  input  logic                rst,
  input  corePipePkg::tWord   instrQ101H,      // From instruction memory
  input  corePipePkg::tWord   pcQ101H,
  input  corePipePkg::tWord   pcPlus4Q101H,
  input  logic                redirectQ102H,
  input  corePipePkg::tWrBack wrBackQ104H,
  output corePipePkg::tDecExe decExeQ102H,
  output logic                stallQ101H
);
  import corePipePkg::*;
  import rvIsaPkg::*;

  logic       killQ101H;      // Wrong-path word or stale word after reset
  logic       squashQ101H;
  tWord       insQ101H;       // Instruction after squash
  tOpcode     opcodeQ101H;
  logic [2:0] funct3Q101H;
  logic [6:0] funct7Q101H;
  tRegAddr    rs1Q101H;
  tRegAddr    rs2Q101H;
  tWord       rs1DataQ101H;
  tWord       rs2DataQ101H;
  tImmType    immTypeQ101H;
  tWord       immQ101H;
  tDecExe     decExeQ101H;

  ////////////////////////////////////////////////////////////
  // Load-use hazard and squash
  ////////////////////////////////////////////////////////////

  // Raw fields here since the squash mux depends on the stall
  assign stallQ101H = decExeQ102H.valid && decExeQ102H.isLoad && (decExeQ102H.rd != '0) &&
                      ((decExeQ102H.rd == instrQ101H[Rs1Lsb +: RegAddrW]) ||
                       (decExeQ102H.rd == instrQ101H[Rs2Lsb +: RegAddrW]));

  assign squashQ101H = killQ101H || redirectQ102H || stallQ101H;
  assign insQ101H    = squashQ101H ? tWord'(NopInstr) : instrQ101H;

  assign opcodeQ101H = tOpcode'(insQ101H[OpcodeW-1:0]);
  assign funct3Q101H = insQ101H[Funct3Lsb +: 3];
  assign funct7Q101H = insQ101H[Funct7Lsb +: 7];
  assign rs1Q101H    = insQ101H[Rs1Lsb +: RegAddrW];
  assign rs2Q101H    = insQ101H[Rs2Lsb +: RegAddrW];

  regFile uRegFile (
    .Clk     (Clk),
    .rst     (rst),
    .rs1     (rs1Q101H),
    .rs2     (rs2Q101H),
    .wrBack  (wrBackQ104H),
    .rs1Data (rs1DataQ101H),
    .rs2Data (rs2DataQ101H)
  );

  ////////////////////////////////////////////////////////////
  // Immediate generator
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (opcodeQ101H)
      Store:      immTypeQ101H = SType;
      Branch:     immTypeQ101H = BType;
      Lui, Auipc: immTypeQ101H = UType;
      Jal:        immTypeQ101H = JType;
      default:    immTypeQ101H = IType;   // OP-IMM and LW and JALR
    endcase
    case (immTypeQ101H)
      SType:   immQ101H = {{20{insQ101H[31]}}, insQ101H[31:25], insQ101H[11:7]};
      BType:   immQ101H = {{20{insQ101H[31]}}, insQ101H[7], insQ101H[30:25], insQ101H[11:8],
                           1'b0};
      UType:   immQ101H = {insQ101H[31:12], 12'b0};
      JType:   immQ101H = {{12{insQ101H[31]}}, insQ101H[19:12], insQ101H[20], insQ101H[30:21],
                           1'b0};
      default: immQ101H = {{20{insQ101H[31]}}, insQ101H[31:20]};
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////////////////////////
  always_comb begin
    decExeQ101H.valid     = !squashQ101H;
    decExeQ101H.pc        = pcQ101H;
    decExeQ101H.pcPlus4   = pcPlus4Q101H;
    decExeQ101H.rs1       = rs1Q101H;
    decExeQ101H.rs2       = rs2Q101H;
    decExeQ101H.rd        = insQ101H[RdLsb +: RegAddrW];
    decExeQ101H.rs1Data   = rs1DataQ101H;
    decExeQ101H.rs2Data   = rs2DataQ101H;
    decExeQ101H.imm       = immQ101H;
    decExeQ101H.branchOp  = tBranchOp'(funct3Q101H);
    decExeQ101H.isBranch  = (opcodeQ101H == Branch);
    decExeQ101H.isJump    = (opcodeQ101H == Jal) || (opcodeQ101H == Jalr);
    decExeQ101H.selAluPc  = opcodeQ101H inside {Jal, Branch, Auipc};
    decExeQ101H.selAluImm = (opcodeQ101H != ROp);           // Only reg-reg takes rs2
    decExeQ101H.isLui     = (opcodeQ101H == Lui);
    decExeQ101H.isLoad    = (opcodeQ101H == Load);          // Always a full word
    decExeQ101H.isStore   = (opcodeQ101H == Store);
    decExeQ101H.regWrEn   = opcodeQ101H inside {Lui, Auipc, Jal, Jalr, Load, IOp, ROp};
    decExeQ101H.aluOp     = Add;                            // Addresses and targets
    if (opcodeQ101H inside {ROp, IOp}) begin
      case (funct3Q101H)
        3'b000:  decExeQ101H.aluOp = (opcodeQ101H == ROp && funct7Q101H[5]) ? Sub : Add;
        3'b001:  decExeQ101H.aluOp = Sll;
        3'b010:  decExeQ101H.aluOp = Slt;
        3'b011:  decExeQ101H.aluOp = Sltu;
        3'b100:  decExeQ101H.aluOp = Xor;
        3'b101:  decExeQ101H.aluOp = funct7Q101H[5] ? Sra : Srl;
        3'b110:  decExeQ101H.aluOp = Or;
        default: decExeQ101H.aluOp = And;
      endcase
    end
  end

  // Q101H to Q102H register
  always_ff @(posedge Clk) begin
    decExeQ102H <= decExeQ101H;
    if (rst) begin
      decExeQ102H.valid <= 1'b0;
    end
  end

  // Second flush slot and the word left in Q101H by reset
  always_ff @(posedge Clk) begin
    if (rst) begin
      killQ101H <= 1'b1;
    end else begin
      killQ101H <= redirectQ102H;
    end
  end

  // The inserted bubble clears the hazard
  assert property (@(posedge Clk) disable iff (rst) stallQ101H |=> !stallQ101H)
    else $error("load-use stall held for two cycles");

endmodule

`default_nettype wire

/* rtl/fetchStage.sv */
// Fetch stage that owns the PC and presents the instruction memory address in Q100H
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
  input  logic              Clk,
  input  logic              rst,
  input  logic              stallQ101H,
  input  logic              redirectQ102H,
  input  corePipePkg::tWord redirectPcQ102H,
  output corePipePkg::tWord pcQ100H,          // To instruction memory
  output corePipePkg::tWord pcQ101H,
  output corePipePkg::tWord pcPlus4Q101H
);
  import corePipePkg::*;

  tWord pcFetchQ100H;    // Next PC to fetch
  tWord pcPlus4Q100H;
  tWord nextPcQ100H;

  assign pcPlus4Q100H = pcFetchQ100H + tWord'(4);
  assign nextPcQ100H  = redirectQ102H ? redirectPcQ102H : pcPlus4Q100H;   // Redirect wins

  // Stalled word is fetched again from its own PC
  // So the memory returns the same instruction next cycle
  assign pcQ100H = stallQ101H ? pcQ101H : pcFetchQ100H;

  always_ff @(posedge Clk) begin
    if (rst) begin
      pcFetchQ100H <= ResetPc;
    end else if (redirectQ102H || !stallQ101H) begin
      pcFetchQ100H <= nextPcQ100H;
    end
  end

  // Q101H copy of the PC held while decode stalls
  always_ff @(posedge Clk) begin
    if (!stallQ101H) begin
      pcQ101H      <= pcFetchQ100H;
      pcPlus4Q101H <= pcPlus4Q100H;    // Link value for JAL and JALR
    end
  end

endmodule

`default_nettype wire

/* rtl/regFile.sv */
// Integer register file with x0 tied to zero and write-back bypass on both read ports
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic                Clk,
  input  logic                rst,
  input  corePipePkg::tRegAddr rs1,
  input  corePipePkg::tRegAddr rs2,
  input  corePipePkg::tWrBack wrBack,
  output corePipePkg::tWord   rs1Data,
  output corePipePkg::tWord   rs2Data
);
  import corePipePkg::*;

  logic [(2**RegAddrW)-1:1][Xlen-1:0] regs;   // x1 to x31

  // Zero first then same-cycle write then the array
  function automatic tWord readPort(tRegAddr addr);
    if (addr == '0) return '0;
    if (wrBack.wrEn && (wrBack.rd == addr)) return wrBack.data;
    return regs[addr];
  endfunction

  always_comb begin
    rs1Data = readPort(rs1);
    rs2Data = readPort(rs2);
  end

  always_ff @(posedge Clk) begin
    if (wrBack.wrEn && (wrBack.rd != '0)) begin
      regs[wrBack.rd] <= wrBack.data;
    end
  end

  assert property (@(posedge Clk) disable iff (rst)
    (wrBack.wrEn && (wrBack.rd == '0)) |=> (regs == $past(regs)))
    else $error("write to x0 changed the register array");

endmodule

`default_nettype wire

/* rtl/corePipePkg.sv */
// Datapath widths and stage-to-stage payload structs shared by every pipeline stage
`default_nettype none

package corePipePkg;

  localparam int Xlen     = 32;
  localparam int RegAddrW = 5;
  localparam int ShamtW   = $clog2(Xlen);   // Shift amount bits
  localparam logic [Xlen-1:0] ResetPc = '0;

  typedef logic [Xlen-1:0]     tWord;
  typedef logic [RegAddrW-1:0] tRegAddr;

  ////////////////////////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////////////////////////

  // Decode to execute
  typedef struct packed {
    logic               valid;       // Low marks a bubble
    tWord               pc;
    tWord               pcPlus4;
    tRegAddr            rs1;
    tRegAddr            rs2;
    tRegAddr            rd;
    tWord               rs1Data;     // Register file value before forwarding
    tWord               rs2Data;
    tWord               imm;
    rvIsaPkg::tAluOp    aluOp;
    rvIsaPkg::tBranchOp branchOp;
    logic               isBranch;
    logic               isJump;      // JAL or JALR
    logic               selAluPc;    // PC into ALU port 1
    logic               selAluImm;   // Immediate into ALU port 2
    logic               isLui;
    logic               isLoad;
    logic               isStore;
    logic               regWrEn;
  } tDecExe;

  // Execute to memory access
  typedef struct packed {
    logic    valid;
    tWord    aluOut;      // Result or memory address
    tWord    storeData;
    tRegAddr rd;
    logic    regWrEn;
    logic    isLoad;
    logic    isStore;
    logic    selWrPc;     // Link value goes to rd
    tWord    pcPlus4;
  } tExeMem;

  // Memory access to write-back
  typedef struct packed {
    logic    valid;
    tWord    aluOut;
    tRegAddr rd;
    logic    regWrEn;
    logic    isLoad;
    logic    selWrPc;
    tWord    pcPlus4;
  } tMemWb;

  // Register write port and forwarding source
  typedef struct packed {
    logic    wrEn;
    tRegAddr rd;
    tWord    data;
  } tWrBack;

endpackage

`default_nettype wire

/* rtl/rvIsaPkg.sv */
// RV32I encoding constants and enums imported by the decode and execute stages
`default_nettype none

package rvIsaPkg;

  ////////////////////////////////////////////////////////////
  // Instruction field positions
  ////////////////////////////////////////////////////////////
  localparam int OpcodeW   = 7;
  localparam int RdLsb     = 7;    // rd in [11:7]
  localparam int Funct3Lsb = 12;
  localparam int Rs1Lsb    = 15;
  localparam int Rs2Lsb    = 20;
  localparam int Funct7Lsb = 25;   // Only bit 30 separates SUB and SRA

  // ADDI x0 x0 0 used for every bubble
  localparam logic [31:0] NopInstr = 32'h0000_0013;

  // Major opcodes
  typedef enum logic [OpcodeW-1:0] {
    Lui    = 7'b0110111,
    Auipc  = 7'b0010111,
    Jal    = 7'b1101111,
    Jalr   = 7'b1100111,
    Branch = 7'b1100011,
    Load   = 7'b0000011,
    Store  = 7'b0100011,
    IOp    = 7'b0010011,
    ROp    = 7'b0110011,
    Fence  = 7'b0001111    // Decoded as a no-op
  } tOpcode;

  typedef enum logic [3:0] {
    Add, Sub, Sll, Slt, Sltu,
    Xor, Srl, Sra, Or, And
  } tAluOp;

  // Values follow funct3 so decode casts straight across
  typedef enum logic [2:0] {
    Beq  = 3'b000,
    Bne  = 3'b001,
    Blt  = 3'b100,
    Bge  = 3'b101,
    Bltu = 3'b110,
    Bgeu = 3'b111
  } tBranchOp;

  typedef enum logic [2:0] {IType, SType, BType, UType, JType} tImmType;

endpackage

`default_nettype wire
